/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f dds_bus_top.f \
		--top-module tb_dds_bus_top -Mdir obj_dir -o vsim
	./obj_dir/vsim | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dds_bus_top.f */
+incdir+design
design/bus_pkg.sv
design/dds_pkg.sv
design/addr_decoder.sv
design/dds_regs.sv
design/phase_accum.sv
design/wave_shaper.sv
design/dds_bus_top.sv
dv/tb_dds_bus_top.sv

/* design/addr_decoder.sv */
`default_nettype none
`timescale 1ns/100ps
`include "dds_defines.svh"

module addr_decoder (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               wr_en,
	input  wire logic [`ADDR_W-1:0] wr_addr,
	input  wire logic [`DATA_W-1:0] wr_data,
	output logic                    resp_valid,
	output bus_pkg::resp_t          resp,
	output logic                    dds_wr,
	output dds_pkg::dds_reg_t       dds_sel,
	output logic [`DATA_W-1:0]      dds_data
);
	import bus_pkg::*;
	import dds_pkg::*;

	logic                   top_bit;
	region_t                region;
	logic [`REGION_LSB-1:0] offset;
	resp_t                  resp_next;
	logic                   dds_hit;

	assign top_bit = wr_addr[`ADDR_W-1];
	assign region  = region_t'(wr_addr[`ADDR_W-2:`REGION_LSB]);
	assign offset  = wr_addr[`REGION_LSB-1:0];

	always_comb begin
		dds_hit = 1'b0;
		if (top_bit) begin
			resp_next = resp_decerr;
		end else if (region != region_dds) begin
			resp_next = resp_slverr; // dropped slaves still decode
		end else if (|offset[`REGION_LSB-1:4] || |offset[1:0]) begin
			resp_next = resp_slverr; // past 0xC or unaligned
		end else begin
			resp_next = resp_okay;
			dds_hit   = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			resp_valid <= 1'b0;
			resp       <= resp_okay;
			dds_wr     <= 1'b0;
			dds_sel    <= reg_ctrl;
			dds_data   <= '0;
		end else begin
			resp_valid <= wr_en;
			dds_wr     <= wr_en && dds_hit;
			if (wr_en)
				resp <= resp_next;
			if (wr_en && dds_hit) begin
				dds_sel  <= dds_reg_t'(offset[3:2]);
				dds_data <= wr_data;
			end
		end
	end

	// register write forwarded only alongside an okay response
	a_okay_forwards: assert property (
		@(posedge clk) disable iff (!rst_n) dds_wr == (resp_valid && resp == resp_okay)
	);

endmodule

`default_nettype wire

/* design/bus_pkg.sv */
`default_nettype none

package bus_pkg;

	// one slave per 256 MB region
	typedef enum logic [2:0] {
		region_ddr,
		region_jtag,
		region_update,
		region_i2c,
		region_dds,
		region_spare5,
		region_spare6,
		region_spare7
	} region_t;

	// axi style write response codes
	typedef enum logic [1:0] {
		resp_okay   = 2'd0,
		resp_slverr = 2'd2, // no device or bad offset
		resp_decerr = 2'd3  // above the map
	} resp_t;

endpackage

`default_nettype wire

/* design/dds_bus_top.sv */
`default_nettype none
`timescale 1ns/100ps
`include "dds_defines.svh"

module dds_bus_top (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               wr_en,
	input  wire logic [`ADDR_W-1:0] wr_addr,
	input  wire logic [`DATA_W-1:0] wr_data,
	output logic                    resp_valid,
	output bus_pkg::resp_t          resp,
	output logic [`WAVE_W-1:0]      da_data
);
	import dds_pkg::*;

	logic                dds_wr;
	dds_reg_t            dds_sel;
	logic [`DATA_W-1:0]  dds_data;
	logic                enable;
	wave_t               wave_sel;
	logic [`PHASE_W-1:0] freq;
	logic [`PHASE_W-1:0] phase_off;
	logic [`AMP_W-1:0]   amp;
	logic [`WAVE_W-1:0]  phase;

	addr_decoder u_addr_decoder (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.resp_valid (resp_valid),
		.resp       (resp),
		.dds_wr     (dds_wr),
		.dds_sel    (dds_sel),
		.dds_data   (dds_data)
	);

	dds_regs u_dds_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.dds_wr    (dds_wr),
		.dds_sel   (dds_sel),
		.dds_data  (dds_data),
		.enable    (enable),
		.wave_sel  (wave_sel),
		.freq      (freq),
		.phase_off (phase_off),
		.amp       (amp)
	);

	phase_accum u_phase_accum (
		.clk       (clk),
		.rst_n     (rst_n),
		.enable    (enable),
		.freq      (freq),
		.phase_off (phase_off),
		.phase     (phase)
	);

	wave_shaper u_wave_shaper (
		.clk      (clk),
		.rst_n    (rst_n),
		.phase    (phase),
		.wave_sel (wave_sel),
		.amp      (amp),
		.da_data  (da_data)
	);

endmodule

`default_nettype wire

/* design/dds_defines.svh */
`ifndef DDS_DEFINES_SVH
`define DDS_DEFINES_SVH

// write bus
`define ADDR_W     32
`define DATA_W     32

// region index sits in bits 30:28, bit 31 is outside the map
`define REGION_LSB 28

// nco
`define PHASE_W    32

// dac sample
`define WAVE_W     8

`define AMP_W      9
`define AMP_UNITY  256 // full scale, da_data == raw sample

`endif

/* design/dds_pkg.sv */
`default_nettype none

package dds_pkg;

	// selected by address bits 3:2
	typedef enum logic [1:0] {
		reg_ctrl,
		reg_freq,
		reg_phase,
		reg_amp
	} dds_reg_t;

	typedef enum logic [1:0] {
		wave_square,
		wave_triangle,
		wave_saw,
		wave_rsvd // outputs 0
	} wave_t;

endpackage

`default_nettype wire

/* design/dds_regs.sv */
`default_nettype none
`timescale 1ns/100ps
`include "dds_defines.svh"

module dds_regs (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                dds_wr,
	input  wire dds_pkg::dds_reg_t   dds_sel,
	input  wire logic [`DATA_W-1:0]  dds_data,
	output logic                     enable,
	output dds_pkg::wave_t           wave_sel,
	output logic [`PHASE_W-1:0]      freq,
	output logic [`PHASE_W-1:0]      phase_off,
	output logic [`AMP_W-1:0]        amp
);
	import dds_pkg::*;

	logic [`AMP_W-1:0] amp_sat;

	// anything past unity clips to full scale
	assign amp_sat = (dds_data > `AMP_UNITY) ? `AMP_W'(`AMP_UNITY)
	                                         : dds_data[`AMP_W-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable    <= 1'b0;
			wave_sel  <= wave_square;
			freq      <= '0;
			phase_off <= '0;
			amp       <= '0;
		end else if (dds_wr) begin
			case (dds_sel)
				reg_ctrl: begin
					enable   <= dds_data[0];
					wave_sel <= wave_t'(dds_data[2:1]);
				end
				reg_freq: begin
					freq <= dds_data[`PHASE_W-1:0];
				end
				reg_phase: begin
					phase_off <= dds_data[`PHASE_W-1:0];
				end
				reg_amp: begin
					amp <= amp_sat;
				end
			endcase
		end
	end

	a_amp_saturated: assert property (
		@(posedge clk) disable iff (!rst_n) amp <= `AMP_UNITY
	);

endmodule

`default_nettype wire

/* design/phase_accum.sv */
`default_nettype none
`timescale 1ns/100ps
`include "dds_defines.svh"

module phase_accum (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                enable,
	input  wire logic [`PHASE_W-1:0] freq,
	input  wire logic [`PHASE_W-1:0] phase_off,
	output logic [`WAVE_W-1:0]       phase
);

	logic [`PHASE_W-1:0] acc;
	logic [`PHASE_W-1:0] sum;

	// offset applied after the accumulator so it shifts phase directly
	assign sum = acc + phase_off;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc <= '0;
		end else if (enable) begin
			acc <= acc + freq; // wraps mod 2^32
		end else begin
			acc <= '0; // held at zero while stopped
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= '0;
		end else begin
			phase <= sum[`PHASE_W-1 -: `WAVE_W]; // top byte only
		end
	end

endmodule

`default_nettype wire

/* design/wave_shaper.sv */
`default_nettype none
`timescale 1ns/100ps
`include "dds_defines.svh"

module wave_shaper (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic [`WAVE_W-1:0] phase,
	input  wire dds_pkg::wave_t     wave_sel,
	input  wire logic [`AMP_W-1:0]  amp,
	output logic [`WAVE_W-1:0]      da_data
);
	import dds_pkg::*;

	logic [`WAVE_W-1:0]   shaped;
	logic [`WAVE_W-1:0]   raw;
	logic [2*`WAVE_W-1:0] scaled;

	always_comb begin
		case (wave_sel)
			wave_square: begin
				shaped = phase[`WAVE_W-1] ? '0 : '1;
			end
			wave_triangle: begin
				// second half folds back, 2*(255-p) == ~p << 1
				if (phase[`WAVE_W-1])
					shaped = {~phase[`WAVE_W-2:0], 1'b0};
				else
					shaped = {phase[`WAVE_W-2:0], 1'b0};
			end
			wave_saw: begin
				shaped = phase;
			end
			default: begin
				shaped = '0;
			end
		endcase
	end

	// max 255 * 256 fits 16 bits
	assign scaled = raw * amp;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			raw     <= '0;
			da_data <= '0;
		end else begin
			raw     <= shaped;                       // stage 1
			da_data <= scaled[2*`WAVE_W-1:`WAVE_W]; // stage 2, >> 8
		end
	end

	// reserved selection reaches the dac as zero
	a_rsvd_is_zero: assert property (
		@(posedge clk) disable iff (!rst_n) wave_sel == wave_rsvd |-> ##2 da_data == '0
	);

endmodule

`default_nettype wire

/* dv/tb_dds_bus_top.sv */
`default_nettype none
`timescale 1ns/100ps
`include "dds_defines.svh"

module tb_dds_bus_top;
	import bus_pkg::*;
	import dds_pkg::*;

	localparam logic [`ADDR_W-1:0] dds_base = 32'h4000_0000;

	logic               clk;
	logic               rst_n;
	logic               wr_en;
	logic [`ADDR_W-1:0] wr_addr;
	logic [`DATA_W-1:0] wr_data;
	logic               resp_valid;
	resp_t              resp;
	logic [`WAVE_W-1:0] da_data;

	resp_t exp_q[$]; // filled by write_bus, drained by the compare process
	logic  wr_seen;

	dds_bus_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.resp_valid (resp_valid),
		.resp       (resp),
		.da_data    (da_data)
	);

	always #10 clk = ~clk;

	function automatic resp_t expected_resp(input logic [`ADDR_W-1:0] addr);
		logic [27:0] off;
		off = addr[27:0];
		if (addr[31])
			return resp_decerr;
		if (addr[30:28] != 3'd4)
			return resp_slverr; // not the dds region
		if (off > 28'hc || off[1:0] != 2'b00)
			return resp_slverr;
		return resp_okay;
	endfunction

	function automatic logic [7:0] expected_sample(input wave_t wave, input int p,
			input int amp);
		int s;
		int a;
		a = (amp > 256) ? 256 : amp;
		case (wave)
			wave_square:   s = (p < 128) ? 255 : 0;
			wave_triangle: s = (p < 128) ? 2 * p : 2 * (255 - p);
			wave_saw:      s = p;
			default:       s = 0;
		endcase
		return 8'((s * a) >> 8);
	endfunction

	task automatic report_mismatch(input string name, input longint expected,
			input longint actual);
		$display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic write_bus(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
		@(posedge clk);
		wr_en   <= 1'b1;
		wr_addr <= addr;
		wr_data <= data;
		exp_q.push_back(expected_resp(addr));
	endtask

	task automatic bus_idle();
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic wait_resp_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
			n++;
			if (n > 16)
				report_error("timeout: write responses still missing after 16 cycles");
		end
	endtask

	// stop first so the accumulator restarts at zero, ctrl last
	task automatic setup_dds(input logic [31:0] ctrl, input logic [31:0] freq,
			input logic [31:0] off, input logic [31:0] amp);
		write_bus(dds_base, 32'd0);
		write_bus(dds_base | 32'h4, freq);
		write_bus(dds_base | 32'h8, off);
		write_bus(dds_base | 32'hc, amp);
		write_bus(dds_base, ctrl);
		bus_idle();
		wait_resp_drain();
	endtask

	always @(negedge clk) begin : compare_resp
		resp_t exp_r;
		if (rst_n) begin
			assert (resp_valid == wr_seen) else
				report_mismatch("resp_timing", wr_seen, resp_valid);
			if (resp_valid) begin
				if (exp_q.size() == 0) begin
					report_error("response pulse seen with no write outstanding");
				end else begin
					exp_r = exp_q.pop_front();
					assert (resp == exp_r) else
						report_mismatch("decode_map", exp_r, resp);
				end
			end
		end
		wr_seen = wr_en; // write seen this cycle, response due next
	end

	initial begin
		wave_t       wave;
		logic [31:0] off;
		logic [31:0] addr;
		logic [7:0]  exp_s;
		logic [7:0]  held;
		int          amp;
		int          k;
		int          prev;
		int          pick;
		clk         = 1'b0;
		rst_n       = 1'b0;
		wr_en       = 1'b0;
		wr_addr     = '0;
		wr_data     = '0;
		wr_seen     = 1'b0;
		void'($urandom(32'h2d79_316e));
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		// reset state
		for (int c = 0; c < 20; c++) begin
			@(negedge clk);
			assert (da_data == 8'd0) else report_mismatch("reset_state", 0, da_data);
			assert (resp_valid == 1'b0) else report_mismatch("reset_resp", 0, resp_valid);
		end

		// decode map, gaps only sometimes
		for (int i = 0; i < 200; i++) begin
			pick = $urandom_range(2);
			case (pick)
				0: addr = $urandom;
				1: addr = dds_base | $urandom_range(31);
				default: addr = 32'h8000_0000 | $urandom;
			endcase
			write_bus(addr, $urandom);
			if ($urandom_range(3) == 0)
				bus_idle();
		end
		bus_idle();
		wait_resp_drain();

		// static waveform, freq 0
		for (int w = 0; w < 4; w++) begin
			for (int t = 0; t < 6; t++) begin
				wave = wave_t'(w);
				off  = $urandom;
				if (t == 0)
					amp = 256;
				else if (t == 1)
					amp = $urandom_range(511, 257); // saturates
				else
					amp = $urandom_range(300);
				setup_dds({29'b0, wave, 1'b1}, 32'd0, off, amp);
				wait_cycles(8);
				@(negedge clk);
				exp_s = expected_sample(wave, off[31:24], amp);
				assert (da_data == exp_s) else report_mismatch("static_wave", exp_s, da_data);
			end
		end

		// accumulation, saw steps by k per sample
		for (int t = 0; t < 3; t++) begin
			k = $urandom_range(255, 1);
			setup_dds({29'b0, wave_saw, 1'b1}, 32'(k) << 24, 32'd0, 32'd256);
			wait_cycles(8);
			@(negedge clk);
			prev = da_data;
			for (int c = 0; c < 64; c++) begin
				@(negedge clk);
				exp_s = 8'(prev + k);
				assert (da_data == exp_s) else report_mismatch("accumulate", exp_s, da_data);
				prev = exp_s;
			end
		end

		// disable drops back to the offset
		for (int t = 0; t < 2; t++) begin
			off = $urandom;
			setup_dds({29'b0, wave_saw, 1'b1}, $urandom | 32'h1, off, 32'd256);
			wait_cycles(8);
			write_bus(dds_base, {29'b0, wave_saw, 1'b0});
			bus_idle();
			wait_resp_drain();
			wait_cycles(8);
			@(negedge clk);
			exp_s = expected_sample(wave_saw, off[31:24], 256);
			assert (da_data == exp_s) else report_mismatch("disable", exp_s, da_data);
		end

		// rejected writes must not touch the registers
		off = $urandom;
		setup_dds({29'b0, wave_triangle, 1'b1}, 32'd0, off, 32'd200);
		wait_cycles(8);
		@(negedge clk);
		held = da_data;
		for (int i = 0; i < 12; i++) begin
			do begin
				pick = $urandom_range(2);
				case (pick)
					0: addr = $urandom;
					1: addr = dds_base | $urandom_range(31);
					default: addr = 32'h8000_0000 | $urandom;
				endcase
			end while (expected_resp(addr) == resp_okay);
			write_bus(addr, $urandom);
			bus_idle();
			for (int c = 0; c < 8; c++) begin
				@(negedge clk);
				assert (da_data == held) else report_mismatch("ignored_write", held, da_data);
			end
			wait_resp_drain();
		end

		wait_resp_drain();
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire
